//--- exCluster.f
common/exPkg.sv
common/laneOpIf.sv
common/laneResultIf.sv
rtl/opDispatch.sv
laneExecute/laneShifter.sv
laneExecute/laneExecute.sv
rtl/resultCollect.sv
rtl/exCluster.sv
verification/exCluster_chk.sv
verification/exClusterTb.sv

//--- Bender.yml
package:
  name: exCluster

sources:
  - files:
      - common/exPkg.sv
      - common/laneOpIf.sv
      - common/laneResultIf.sv
      - rtl/opDispatch.sv
      - laneExecute/laneShifter.sv
      - laneExecute/laneExecute.sv
      - rtl/resultCollect.sv
      - rtl/exCluster.sv
  - target: test
    files:
      - verification/exCluster_chk.sv
      - verification/exClusterTb.sv

//--- verification/exClusterTb.sv
// ====================
// Testbench for the execute cluster
// Clock, reset, LFSR stimulus, reference model,
// in-order scoreboard and cycle timeout
// ====================
`timescale 1ns/100ps
`default_nettype none

module exClusterTb;

	localparam int numLanes    = 2;
	localparam int resetCycles = 10;
	localparam int randCycles  = 400;
	localparam int tailCycles  = 8;   // Fault ops plus drain
	localparam int cycleLimit  = 2 * (randCycles + tailCycles + 2) + resetCycles;

	typedef struct packed {
		logic           [numLanes-1:0] write;
		logic           [numLanes-1:0] fault;
		exPkg::regId_t  [numLanes-1:0] id;
		exPkg::regVal_t [numLanes-1:0] val;
	} predRec_t;

	logic                                 clock;
	logic                                 arstN;
	logic                                 stall;
	logic                                 flush;
	logic                                 srT;
	logic           [numLanes-1:0][7:0]   opCmd;
	exPkg::uIxt_t   [numLanes-1:0]        opIxt;
	exPkg::regId_t  [numLanes-1:0]        regIdRs;
	exPkg::regId_t  [numLanes-1:0]        regIdRm;
	exPkg::regVal_t [numLanes-1:0]        regValRs;
	exPkg::regVal_t [numLanes-1:0]        regValRt;
	exPkg::imm_t    [numLanes-1:0]        regValImm;
	logic           [numLanes-1:0]        resWrite;
	exPkg::regId_t  [numLanes-1:0]        resId;
	exPkg::regVal_t [numLanes-1:0]        resVal;
	logic                                 exHold;
	logic                                 faultValid;
	exPkg::laneIdx_t                      faultLane;

	logic [31:0]     lfsr;
	predRec_t        pipeQ [$];     // Op waiting in the dispatch stage
	predRec_t        pending;       // Prediction for the inputs now driven
	predRec_t        outExp;        // Expected output register contents
	logic            lastStall;
	logic            fvExp;
	exPkg::laneIdx_t flExp;
	int              cycleCount = 0;
	exPkg::uCmd_t    opList [16];   // NOP entry selects the passive group
	exPkg::uCmd_t    passiveList [8];

	exCluster #(
		.numLanes (numLanes)
	) DUT (
		.clock      (clock),
		.arstN      (arstN),
		.stall      (stall),
		.flush      (flush),
		.srT        (srT),
		.opCmd      (opCmd),
		.opIxt      (opIxt),
		.regIdRs    (regIdRs),
		.regIdRm    (regIdRm),
		.regValRs   (regValRs),
		.regValRt   (regValRt),
		.regValImm  (regValImm),
		.resWrite   (resWrite),
		.resId      (resId),
		.resVal     (resVal),
		.exHold     (exHold),
		.faultValid (faultValid),
		.faultLane  (faultLane)
	);

	bind exCluster exClusterChk #(
		.numLanes (numLanes)
	) uChk (
		.clock      (clock),
		.arstN      (arstN),
		.stall      (stall),
		.resWrite   (resWrite),
		.resId      (resId),
		.resVal     (resVal),
		.exHold     (exHold),
		.faultValid (faultValid),
		.faultLane  (faultLane)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("Regression failed");
			$fatal(1, "Cycle limit reached");
		end
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic drawBits(input int n, output logic [63:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsrNext(lfsr);
			v = {v[62:0], lfsr[0]};
		end
	endtask

	task automatic compareValue(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
			$display("Regression failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// Shifts one bit per step so large magnitudes drain to zero or sign bits
	function automatic exPkg::regVal_t shiftModel(input exPkg::regVal_t v,
			input logic [7:0] amt, input logic arith, input logic wide);
		int             w;
		int             sa;
		int             mag;
		logic           fill;
		exPkg::regVal_t r;
		w   = wide ? 64 : 32;
		sa  = $signed(amt);
		mag = (sa < 0) ? -sa : sa;
		r   = wide ? v : {32'h0, v[31:0]};
		for (int k = 0; k < mag; k++) begin
			if (sa >= 0) begin
				r = r << 1;
			end else begin
				fill   = arith & r[w-1];
				r      = r >> 1;
				r[w-1] = fill;
			end
		end
		return wide ? r : {32'h0, r[31:0]};
	endfunction

	task automatic predictLane(input int i, output logic wr, output logic flt,
			output exPkg::regVal_t val);
		exPkg::cond_e   cond;
		logic           en;
		exPkg::uCmd_t   cmd;
		exPkg::uIxt_t   ixt;
		exPkg::regVal_t rs;
		exPkg::imm_t    imm;
		exPkg::regVal_t sh;
		cond = exPkg::cond_e'(opCmd[i][7:6]);
		en   = !flush && (cond == exPkg::condAlways || (cond == exPkg::condTrue && srT)
			|| (cond == exPkg::condFalse && !srT));
		cmd  = en ? opCmd[i][5:0] : exPkg::NOP;
		ixt  = opIxt[i];
		rs   = regValRs[i];
		imm  = regValImm[i];
		sh   = shiftModel(rs, regValRt[i][7:0], cmd == exPkg::SHAD3 || cmd == exPkg::SHADQ3,
			cmd == exPkg::SHADQ3 || cmd == exPkg::SHLDQ3);
		wr   = 1'b1;
		flt  = 1'b0;
		val  = '0;
		case (cmd)
			exPkg::MOV_IR:
				case (ixt[1:0])
					2'd0:    val = 64'($signed(imm));
					2'd1:    val = (rs << 8) | 64'(imm[7:0]);
					2'd2:    val = (rs << 16) | 64'(imm[15:0]);
					default: val = (rs << 32) | 64'(imm[31:0]);
				endcase
			exPkg::CONV_RR:
				case (ixt[1:0])
					2'd0:    val = 64'($signed(rs[7:0]));
					2'd1:    val = 64'($signed(rs[15:0]));
					2'd2:    val = 64'($signed(rs[31:0]));
					default: val = 64'(rs[31:0]);
				endcase
			exPkg::SHAD3:                 val = 64'($signed(sh[31:0]));
			exPkg::SHLD3:                 val = 64'(sh[31:0]);
			exPkg::SHADQ3, exPkg::SHLDQ3: val = sh;
			exPkg::OP_IXS: begin
				if (ixt == exPkg::IXS_MOVT) begin
					val = 64'(srT);
				end else if (ixt == exPkg::IXS_MOVNT) begin
					val = 64'(!srT);
				end else begin
					wr  = 1'b0;
					flt = (ixt != exPkg::IXS_NOP);
				end
			end
			exPkg::OP_IXT: begin
				wr  = 1'b0;
				flt = !(ixt == exPkg::IXT_NOP || ixt == exPkg::IXT_SLEEP);
			end
			exPkg::NOP, exPkg::LEA_MR, exPkg::MOV_RM, exPkg::MOV_MR, exPkg::ALU3, exPkg::MUL3:
				wr = 1'b0;
			default: begin
				wr  = 1'b0;
				flt = 1'b1;   // INVOP and unlisted opcodes
			end
		endcase
	endtask

	task automatic predictCycle();
		logic           wr;
		logic           flt;
		exPkg::regVal_t val;
		for (int i = 0; i < numLanes; i++) begin
			predictLane(i, wr, flt, val);
			pending.write[i] = wr;
			pending.fault[i] = flt;
			pending.val[i]   = val;
			pending.id[i]    = regIdRm[i];
		end
		lastStall = stall;
	endtask

	task automatic setLane(input int i, input logic [7:0] cmd8, input exPkg::uIxt_t ixt);
		logic [63:0] r;
		opCmd[i] = cmd8;
		opIxt[i] = ixt;
		drawBits(6, r);
		regIdRs[i] = r[5:0];
		drawBits(6, r);
		regIdRm[i] = r[5:0];
		drawBits(64, r);
		regValRs[i] = r;
		drawBits(64, r);
		regValRt[i] = r;
		drawBits(33, r);
		regValImm[i] = r[32:0];
	endtask

	task automatic driveRandom();
		logic [63:0]  r;
		exPkg::uCmd_t op;
		exPkg::uIxt_t ixt;
		logic [1:0]   cond;
		drawBits(3, r);
		stall = (r[2:0] == 3'd0);
		drawBits(4, r);
		flush = (r[3:0] == 4'd0);
		drawBits(1, r);
		srT = r[0];
		for (int i = 0; i < numLanes; i++) begin
			drawBits(4, r);
			op = opList[r[3:0]];
			if (op == exPkg::NOP) begin
				drawBits(3, r);
				op = passiveList[r[2:0]];
			end
			drawBits(6, r);
			ixt = r[5:0];
			if (op == exPkg::OP_IXS)
				ixt = exPkg::uIxt_t'(r[5:0] % 3);   // NOP, MOVT or MOVNT
			if (op == exPkg::OP_IXT)
				ixt = {5'b0, r[0]};                 // NOP or SLEEP
			drawBits(3, r);
			cond = r[2] ? r[1:0] : exPkg::condAlways;
			setLane(i, {cond, op}, ixt);
		end
		predictCycle();
	endtask

	task automatic driveFixed(input logic [7:0] c0, input exPkg::uIxt_t x0,
			input logic [7:0] c1, input exPkg::uIxt_t x1);
		logic [63:0] r;
		stall = 1'b0;
		flush = 1'b0;
		drawBits(1, r);
		srT = r[0];
		setLane(0, c0, x0);
		setLane(1, c1, x1);
		predictCycle();
	endtask

	// Compares at the falling edge after the rising edge has settled
	task automatic checkCycle();
		@(negedge clock);
		if (DUT.uChk.failCount != 0) begin
			$display("A bound assertion failed before t=%0t", $time);
			$display("Regression failed");
			$fatal(1, "Assertion failure");
		end
		if (!lastStall) begin
			pipeQ.push_back(pending);
			outExp = pipeQ.pop_front();
			if (|outExp.fault && !fvExp) begin
				fvExp = 1'b1;
				flExp = '0;
				while (!outExp.fault[flExp])
					flExp++;
			end
		end
		for (int i = 0; i < numLanes; i++) begin
			compareValue($sformatf("resWrite[%0d]", i), resWrite[i], outExp.write[i]);
			if (outExp.write[i]) begin
				compareValue($sformatf("resId[%0d]", i), resId[i], outExp.id[i]);
				compareValue($sformatf("resVal[%0d]", i), resVal[i], outExp.val[i]);
			end
		end
		compareValue("exHold", exHold, |outExp.fault);
		compareValue("faultValid", faultValid, fvExp);
		if (fvExp)
			compareValue("faultLane", faultLane, flExp);
	endtask

	initial begin
		lfsr        = 32'habb9d820;
		arstN       = 1'b0;
		stall       = 1'b0;
		flush       = 1'b0;
		srT         = 1'b0;
		opCmd       = '0;
		opIxt       = '0;
		regIdRs     = '0;
		regIdRm     = '0;
		regValRs    = '0;
		regValRt    = '0;
		regValImm   = '0;
		opList      = '{exPkg::MOV_IR, exPkg::MOV_IR, exPkg::MOV_IR, exPkg::SHAD3,
			exPkg::SHAD3, exPkg::SHLD3, exPkg::SHLD3, exPkg::SHADQ3, exPkg::SHADQ3,
			exPkg::SHLDQ3, exPkg::SHLDQ3, exPkg::CONV_RR, exPkg::CONV_RR, exPkg::OP_IXS,
			exPkg::OP_IXT, exPkg::NOP};
		passiveList = '{exPkg::NOP, exPkg::LEA_MR, exPkg::MOV_RM, exPkg::MOV_MR,
			exPkg::ALU3, exPkg::MUL3, exPkg::NOP, exPkg::ALU3};
		fvExp       = 1'b0;
		flExp       = '0;
		outExp      = '0;
		pipeQ.push_back('0);   // Dispatch stage holds NOP after reset
		repeat (resetCycles) @(negedge clock);
		arstN = 1'b1;
		driveRandom();
		repeat (randCycles) begin
			checkCycle();
			driveRandom();
		end
		// Lane 0 wins when both lanes fault together
		checkCycle();
		driveFixed({exPkg::condAlways, 6'h3F}, '0, {exPkg::condAlways, exPkg::INVOP}, '0);
		checkCycle();
		driveFixed(8'h00, '0, {exPkg::condAlways, exPkg::OP_IXT}, exPkg::IXT_BREAK);
		checkCycle();
		driveFixed({exPkg::condAlways, exPkg::OP_IXS}, 6'h05, 8'h00, '0);
		repeat (tailCycles - 3) begin
			checkCycle();
			driveFixed(8'h00, '0, 8'h00, '0);
		end
		checkCycle();
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/exCluster_chk.sv
// ====================
// Bound assertions on the cluster outputs
// Reset values, stall stability,
// sticky fault record
// ====================
`timescale 1ns/100ps
`default_nettype none

module exClusterChk #(
	parameter int numLanes = 2
) (
	input logic                           clock,
	input logic                           arstN,
	input logic                           stall,
	input logic           [numLanes-1:0]  resWrite,
	input exPkg::regId_t  [numLanes-1:0]  resId,
	input exPkg::regVal_t [numLanes-1:0]  resVal,
	input logic                           exHold,
	input logic                           faultValid,
	input exPkg::laneIdx_t                faultLane
);

	int failCount = 0;  // Failed assertions so far

	resetClear: assert property (@(posedge clock)
		!arstN |-> (resWrite == '0) && !exHold)
		else begin
			failCount = failCount + 1;
			$error("resWrite or exHold set while reset is asserted");
		end

	// A stalled edge leaves the output registers untouched
	stallHold: assert property (@(posedge clock) disable iff (!arstN)
		$past(stall) |-> $stable(resWrite) && $stable(resId) && $stable(resVal)
			&& $stable(exHold) && $stable(faultValid) && $stable(faultLane))
		else begin
			failCount = failCount + 1;
			$error("Outputs changed across a stalled cycle");
		end

	faultSticky: assert property (@(posedge clock) disable iff (!arstN)
		!$fell(faultValid))
		else begin
			failCount = failCount + 1;
			$error("faultValid dropped without reset");
		end

endmodule

`default_nettype wire

//--- rtl/exCluster.sv
// ====================
// Execute-1 cluster for the secondary lanes
// Dispatcher, lane executors, collector
// ====================
`timescale 1ns/100ps
`default_nettype none

module exCluster #(
	parameter int numLanes = 2  // 1 to 16
) (
	input  logic                                  clock,
	input  logic                                  arstN,
	input  logic                                  stall,
	input  logic                                  flush,
	input  logic                                  srT,
	input  logic           [numLanes-1:0][7:0]    opCmd,
	input  exPkg::uIxt_t   [numLanes-1:0]         opIxt,
	input  exPkg::regId_t  [numLanes-1:0]         regIdRs,
	input  exPkg::regId_t  [numLanes-1:0]         regIdRm,
	input  exPkg::regVal_t [numLanes-1:0]         regValRs,
	input  exPkg::regVal_t [numLanes-1:0]         regValRt,
	input  exPkg::imm_t    [numLanes-1:0]         regValImm,
	output logic           [numLanes-1:0]         resWrite,
	output exPkg::regId_t  [numLanes-1:0]         resId,
	output exPkg::regVal_t [numLanes-1:0]         resVal,
	output logic                                  exHold,
	output logic                                  faultValid,
	output exPkg::laneIdx_t                       faultLane
);

	laneOpIf     laneOps [numLanes] ();
	laneResultIf laneRes [numLanes] ();

	opDispatch #(
		.numLanes (numLanes)
	) uDispatch (
		.clock     (clock),
		.arstN     (arstN),
		.stall     (stall),
		.flush     (flush),
		.srT       (srT),
		.opCmd     (opCmd),
		.opIxt     (opIxt),
		.regIdRs   (regIdRs),
		.regIdRm   (regIdRm),
		.regValRs  (regValRs),
		.regValRt  (regValRt),
		.regValImm (regValImm),
		.ops       (laneOps)
	);

	for (genvar i = 0; i < numLanes; i++) begin : gLane
		laneExecute uLane (
			.op  (laneOps[i]),
			.res (laneRes[i])
		);
	end

	resultCollect #(
		.numLanes (numLanes)
	) uCollect (
		.clock      (clock),
		.arstN      (arstN),
		.stall      (stall),
		.lanes      (laneRes),
		.resWrite   (resWrite),
		.resId      (resId),
		.resVal     (resVal),
		.exHold     (exHold),
		.faultValid (faultValid),
		.faultLane  (faultLane)
	);

endmodule

`default_nettype wire

//--- rtl/resultCollect.sv
// ====================
// Result register stage
// Per-lane destination writes, hold merge
// and the sticky first-fault record
// ====================
`timescale 1ns/100ps
`default_nettype none

module resultCollect #(
	parameter int numLanes = 2
) (
	input  logic                                  clock,
	input  logic                                  arstN,
	input  logic                                  stall,
	laneResultIf.collect                          lanes [numLanes],
	output logic           [numLanes-1:0]         resWrite,
	output exPkg::regId_t  [numLanes-1:0]         resId,
	output exPkg::regVal_t [numLanes-1:0]         resVal,
	output logic                                  exHold,
	output logic                                  faultValid,
	output exPkg::laneIdx_t                       faultLane
);

	logic           [numLanes-1:0] laneWrite;
	logic           [numLanes-1:0] laneFault;
	exPkg::regId_t  [numLanes-1:0] laneId;
	exPkg::regVal_t [numLanes-1:0] laneVal;
	exPkg::laneIdx_t               firstLane;

	for (genvar i = 0; i < numLanes; i++) begin : gUnpack
		assign laneWrite[i] = lanes[i].write;
		assign laneFault[i] = lanes[i].fault;
		assign laneId[i]    = lanes[i].destId;
		assign laneVal[i]   = lanes[i].value;
	end

	// Lowest faulting lane wins
	always_comb begin
		firstLane = '0;
		for (int i = numLanes - 1; i >= 0; i--) begin
			if (laneFault[i])
				firstLane = exPkg::laneIdx_t'(i);
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			resWrite   <= '0;
			exHold     <= 1'b0;
			faultValid <= 1'b0;
			faultLane  <= '0;
		end else if (!stall) begin
			resWrite <= laneWrite;
			exHold   <= |laneFault;
			if (!faultValid && |laneFault) begin  // Only the first fault is kept
				faultValid <= 1'b1;
				faultLane  <= firstLane;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			resId  <= laneId;
			resVal <= laneVal;
		end
	end

endmodule

`default_nettype wire

//--- laneExecute/laneExecute.sv
// ====================
// Lane executor
// Decodes one micro-op and selects the
// destination value, write enable and fault
// ====================
`timescale 1ns/100ps
`default_nettype none

module laneExecute (
	laneOpIf.lane     op,
	laneResultIf.lane res
);

	logic           shArith;
	logic           shWide;
	exPkg::regVal_t shOut;
	logic           wrEn;
	exPkg::regVal_t wrVal;
	logic           isFault;

	assign shArith = (op.cmd == exPkg::SHAD3) || (op.cmd == exPkg::SHADQ3);
	assign shWide  = (op.cmd == exPkg::SHADQ3) || (op.cmd == exPkg::SHLDQ3);

	laneShifter uShifter (
		.value  (op.valRs),
		.amount (op.valRt[7:0]),   // Signed amount from Rt
		.arith  (shArith),
		.wide   (shWide),
		.result (shOut)
	);

	always_comb begin
		wrEn    = 1'b0;
		wrVal   = '0;
		isFault = 1'b0;

		case (op.cmd)
			exPkg::NOP, exPkg::LEA_MR, exPkg::MOV_RM, exPkg::MOV_MR,
			exPkg::ALU3, exPkg::MUL3: begin
				// Owned by other lanes or stages
			end
			exPkg::INVOP:
				isFault = 1'b1;
			exPkg::CONV_RR: begin
				wrEn = 1'b1;
				case (op.ixt[1:0])
					2'd0:    wrVal = {{56{op.valRs[7]}}, op.valRs[7:0]};
					2'd1:    wrVal = {{48{op.valRs[15]}}, op.valRs[15:0]};
					2'd2:    wrVal = {{32{op.valRs[31]}}, op.valRs[31:0]};
					default: wrVal = {32'h0, op.valRs[31:0]};  // Zero-extend dword
				endcase
			end
			exPkg::MOV_IR: begin
				wrEn = 1'b1;
				case (op.ixt[1:0])
					2'd0:    wrVal = {{31{op.imm[32]}}, op.imm};         // LDI
					2'd1:    wrVal = {op.valRs[55:0], op.imm[7:0]};      // LDISH8
					2'd2:    wrVal = {op.valRs[47:0], op.imm[15:0]};     // LDISH16
					default: wrVal = {op.valRs[31:0], op.imm[31:0]};     // LDISH32
				endcase
			end
			exPkg::SHAD3: begin
				wrEn  = 1'b1;
				wrVal = {{32{shOut[31]}}, shOut[31:0]};
			end
			exPkg::SHLD3: begin
				wrEn  = 1'b1;
				wrVal = {32'h0, shOut[31:0]};
			end
			exPkg::SHADQ3, exPkg::SHLDQ3: begin
				wrEn  = 1'b1;
				wrVal = shOut;
			end
			exPkg::OP_IXS: begin
				case (op.ixt)
					exPkg::IXS_NOP: begin
					end
					exPkg::IXS_MOVT: begin
						wrEn  = 1'b1;
						wrVal = {63'h0, op.srT};
					end
					exPkg::IXS_MOVNT: begin
						wrEn  = 1'b1;
						wrVal = {63'h0, !op.srT};
					end
					default:
						isFault = 1'b1;  // Unhandled IXS
				endcase
			end
			exPkg::OP_IXT: begin
				case (op.ixt)
					exPkg::IXT_NOP, exPkg::IXT_SLEEP: begin
					end
					exPkg::IXT_BREAK:
						isFault = 1'b1;
					default:
						isFault = 1'b1;  // Unhandled IXT
				endcase
			end
			default:
				isFault = 1'b1;  // Unhandled opcode
		endcase
	end

	assign res.write  = wrEn;
	assign res.destId = wrEn ? op.idRm : exPkg::zeroReg;
	assign res.value  = wrVal;
	assign res.fault  = isFault;

endmodule

`default_nettype wire

//--- laneExecute/laneShifter.sv
// ====================
// Barrel shifter, 32 or 64 bits wide
// Signed amount: left when positive,
// right by the magnitude when negative
// ====================
`timescale 1ns/100ps
`default_nettype none

module laneShifter (
	input  exPkg::regVal_t    value,
	input  logic signed [7:0] amount,
	input  logic              arith,    // Arithmetic right shift
	input  logic              wide,     // 64-bit mode
	output exPkg::regVal_t    result
);

	logic                rightShift;
	logic [8:0]          mag;        // Holds 128 for an amount of -128
	logic                inRange;
	logic                fillBit;
	exPkg::regVal_t      operand;
	logic signed [63:0]  sOperand;
	exPkg::regVal_t      shifted;

	always_comb begin
		rightShift = amount[7];
		mag        = rightShift ? (9'd0 - {amount[7], amount}) : {1'b0, amount};
		inRange    = mag < (wide ? 9'd64 : 9'd32);

		// Narrow mode works on the low half, extended for right shifts
		operand  = wide ? value : {{32{arith & value[31]}}, value[31:0]};
		sOperand = operand;
		fillBit  = arith & rightShift & (wide ? value[63] : value[31]);

		if (!inRange)
			shifted = {64{fillBit}};
		else if (!rightShift)
			shifted = operand << mag[5:0];
		else if (arith)
			shifted = sOperand >>> mag[5:0];
		else
			shifted = operand >> mag[5:0];

		result = wide ? shifted : {32'h0, shifted[31:0]};
	end

endmodule

`default_nettype wire

//--- rtl/opDispatch.sv
// ====================
// Dispatch register stage
// Splits lane bundles, evaluates the condition
// and flush, registers the micro-ops under stall
// ====================
`timescale 1ns/100ps
`default_nettype none

module opDispatch #(
	parameter int numLanes = 2
) (
	input  logic                                  clock,
	input  logic                                  arstN,
	input  logic                                  stall,
	input  logic                                  flush,
	input  logic                                  srT,
	input  logic           [numLanes-1:0][7:0]    opCmd,
	input  exPkg::uIxt_t   [numLanes-1:0]         opIxt,
	input  exPkg::regId_t  [numLanes-1:0]         regIdRs,
	input  exPkg::regId_t  [numLanes-1:0]         regIdRm,
	input  exPkg::regVal_t [numLanes-1:0]         regValRs,
	input  exPkg::regVal_t [numLanes-1:0]         regValRt,
	input  exPkg::imm_t    [numLanes-1:0]         regValImm,
	laneOpIf.dispatch                             ops [numLanes]
);

	logic srTQ;  // Shared by all lanes

	always_ff @(posedge clock) begin
		if (!stall)
			srTQ <= srT;
	end

	for (genvar i = 0; i < numLanes; i++) begin : gLane
		exPkg::cond_e   cond;
		logic           enable;
		exPkg::uCmd_t   cmdQ;
		exPkg::uIxt_t   ixtQ;
		exPkg::regId_t  idRsQ;
		exPkg::regId_t  idRmQ;
		exPkg::regVal_t valRsQ;
		exPkg::regVal_t valRtQ;
		exPkg::imm_t    immQ;

		assign cond = exPkg::cond_e'(opCmd[i][7:6]);

		// Predicate against T and the branch flush
		always_comb begin
			case (cond)
				exPkg::condAlways: enable = 1'b1;
				exPkg::condNever:  enable = 1'b0;
				exPkg::condTrue:   enable = srT;
				default:           enable = !srT;
			endcase
			if (flush)
				enable = 1'b0;
		end

		always_ff @(posedge clock or negedge arstN) begin
			if (!arstN)
				cmdQ <= exPkg::NOP;
			else if (!stall)
				cmdQ <= enable ? opCmd[i][5:0] : exPkg::NOP;  // Disabled ops become NOP
		end

		always_ff @(posedge clock) begin
			if (!stall) begin
				ixtQ   <= opIxt[i];
				idRsQ  <= regIdRs[i];
				idRmQ  <= regIdRm[i];
				valRsQ <= regValRs[i];
				valRtQ <= regValRt[i];
				immQ   <= regValImm[i];
			end
		end

		assign ops[i].cmd   = cmdQ;
		assign ops[i].ixt   = ixtQ;
		assign ops[i].idRs  = idRsQ;
		assign ops[i].idRm  = idRmQ;
		assign ops[i].valRs = valRsQ;
		assign ops[i].valRt = valRtQ;
		assign ops[i].imm   = immQ;
		assign ops[i].srT   = srTQ;
	end

endmodule

`default_nettype wire

//--- common/laneResultIf.sv
// ====================
// One lane's result and fault
// Lane executor to collector
// ====================
`timescale 1ns/100ps
`default_nettype none

interface laneResultIf;

	logic           write;   // Destination write enable
	exPkg::regId_t  destId;
	exPkg::regVal_t value;
	logic           fault;   // Invalid, unhandled or BREAK

	modport lane (
		output write, destId, value, fault
	);

	modport collect (
		input write, destId, value, fault
	);

endinterface

`default_nettype wire

//--- common/laneOpIf.sv
// ====================
// One predicated micro-op
// Dispatcher to lane executor
// ====================
`timescale 1ns/100ps
`default_nettype none

interface laneOpIf;

	exPkg::uCmd_t   cmd;     // NOP when predicated off
	exPkg::uIxt_t   ixt;
	exPkg::regId_t  idRs;
	exPkg::regId_t  idRm;    // Destination register
	exPkg::regVal_t valRs;
	exPkg::regVal_t valRt;   // Low byte is the shift amount
	exPkg::imm_t    imm;
	logic           srT;     // Registered T bit

	modport dispatch (
		output cmd, ixt, idRs, idRm, valRs, valRt, imm, srT
	);

	modport lane (
		input cmd, ixt, idRs, idRm, valRs, valRt, imm, srT
	);

endinterface

`default_nettype wire

//--- common/exPkg.sv
// ====================
// Shared types and constants for the execute cluster
// Register, value and immediate widths
// Micro-op and sub-op encodings
// Condition field enum
// ====================
`default_nettype none

package exPkg;

	typedef logic [5:0]  regId_t;       // Register number
	typedef logic [63:0] regVal_t;      // Register value
	typedef logic [32:0] imm_t;         // Bit 32 is the sign extension bit
	typedef logic [5:0]  uCmd_t;        // Micro-op opcode
	typedef logic [5:0]  uIxt_t;        // Sub-op field
	typedef logic [3:0]  laneIdx_t;     // Lane number, up to 16 lanes

	// Top two bits of each 8-bit command
	typedef enum logic [1:0] {
		condAlways = 2'b00,
		condNever  = 2'b01,
		condTrue   = 2'b10,
		condFalse  = 2'b11
	} cond_e;

	localparam regId_t zeroReg = 6'h00;  // No destination

	// Micro-op opcodes
	localparam uCmd_t NOP     = 6'h00;
	localparam uCmd_t INVOP   = 6'h01;
	localparam uCmd_t LEA_MR  = 6'h02;
	localparam uCmd_t MOV_RM  = 6'h03;
	localparam uCmd_t MOV_MR  = 6'h04;
	localparam uCmd_t ALU3    = 6'h05;
	localparam uCmd_t MUL3    = 6'h06;
	localparam uCmd_t CONV_RR = 6'h07;  // Extension picked by ixt[1:0]
	localparam uCmd_t MOV_IR  = 6'h08;  // LDI and LDISH picked by ixt[1:0]
	localparam uCmd_t SHAD3   = 6'h09;
	localparam uCmd_t SHLD3   = 6'h0A;
	localparam uCmd_t SHADQ3  = 6'h0B;
	localparam uCmd_t SHLDQ3  = 6'h0C;
	localparam uCmd_t OP_IXS  = 6'h0D;
	localparam uCmd_t OP_IXT  = 6'h0E;

	// OP_IXS sub-ops
	localparam uIxt_t IXS_NOP   = 6'h00;
	localparam uIxt_t IXS_MOVT  = 6'h01;
	localparam uIxt_t IXS_MOVNT = 6'h02;

	// OP_IXT sub-ops
	localparam uIxt_t IXT_NOP   = 6'h00;
	localparam uIxt_t IXT_SLEEP = 6'h01;
	localparam uIxt_t IXT_BREAK = 6'h02;

endpackage

`default_nettype wire
